/* verilog/l2_params.svh */
// ##############################
// l2 front end parameters
// requester count, queue depth and
// the data and word address widths
// ##############################

`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// number of requesters sharing the bridge
`define L2_NUM_PORTS 4

// entries in each per-port request queue, power of two
`define L2_QUEUE_DEPTH 4

// data word width in bits
`define L2_DATA_W 32

// word address width, AXI byte address appends two zero bits
`define L2_ADDR_W 30

`endif

/* verilog/l2_types_pkg.sv */
// ##############################
// requester side types
// words, addresses, port ids and the
// request and response structs
// ##############################

`include "l2_params.svh"

package l2_types_pkg;

    typedef logic [`L2_DATA_W-1:0] word_t;
    typedef logic [`L2_ADDR_W-1:0] word_addr_t;
    typedef logic [$clog2(`L2_NUM_PORTS)-1:0] port_id_t;

    // beats minus one, up to four words per read
    typedef logic [1:0] burst_len_t;
    typedef logic [`L2_DATA_W/8-1:0] byte_en_t;

    typedef enum logic [2:0] {
        AMO_SWAP,
        AMO_ADD,
        AMO_AND,
        AMO_OR,
        AMO_XOR,
        AMO_MAX,
        AMO_MIN
    } amo_op_e;

    typedef enum logic [1:0] {
        REQ_READ,
        REQ_WRITE,
        REQ_ATOMIC
    } req_kind_e;

    typedef struct packed {
        req_kind_e  kind;
        word_addr_t addr;
        burst_len_t len;
        byte_en_t   be;
        amo_op_e    op;
        // write data, or operand of an atomic
        word_t      data;
    } l2_request_t;

    typedef struct packed {
        port_id_t port;
        word_t    data;
        logic     last;
    } l2_response_t;

endpackage

/* verilog/axi_types_pkg.sv */
// ##############################
// AXI4 channel types
// AR, R, AW, W and B payloads and
// the bridge state encoding
// ##############################

`include "l2_params.svh"

package axi_types_pkg;

    typedef logic [`L2_ADDR_W+1:0] axi_addr_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    // 4 byte beats, incrementing bursts
    localparam axi_size_t AXI_SIZE_WORD = 3'b010;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

    typedef struct packed {
        l2_types_pkg::port_id_t id;
        axi_addr_t              addr;
        axi_len_t               len;
        axi_size_t              size;
        axi_burst_t             burst;
    } axi_ar_t;

    typedef struct packed {
        l2_types_pkg::port_id_t id;
        l2_types_pkg::word_t    data;
        axi_resp_t              resp;
        logic                   last;
    } axi_r_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        l2_types_pkg::word_t    data;
        l2_types_pkg::byte_en_t strb;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        l2_types_pkg::port_id_t id;
        axi_resp_t              resp;
    } axi_b_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_ADDR,
        WRITE_DATA,
        WRITE_RESP
    } bridge_state_e;

endpackage

/* verilog/port_request_queue.sv */
// ##############################
// per-port request queue
// circular buffer of requests with a
// full level for back-pressure
// ##############################

`timescale 1ns/1ns

`include "l2_params.svh"

module port_request_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  l2_types_pkg::l2_request_t push_req,
    output logic                      full,
    output logic                      head_valid,
    output l2_types_pkg::l2_request_t head,
    input  logic                      pop
);
    import l2_types_pkg::*;

    localparam int PTR_W = $clog2(`L2_QUEUE_DEPTH);

    l2_request_t entries [`L2_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic do_push;
    logic do_pop;

    // pushes while full are dropped here
    assign do_push = push && !full;
    assign do_pop = pop && head_valid;

    assign full = (count == (PTR_W+1)'(`L2_QUEUE_DEPTH));
    assign head_valid = (count != '0);
    assign head = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* verilog/request_arbiter.sv */
// ##############################
// round-robin request arbiter
// picks a non-empty queue after the
// last granted port, pops on accept
// ##############################

`timescale 1ns/1ns

`include "l2_params.svh"

module request_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`L2_NUM_PORTS-1:0]  head_valid,
    input  l2_types_pkg::l2_request_t heads [`L2_NUM_PORTS],
    output logic [`L2_NUM_PORTS-1:0]  pop,
    output logic                      grant_valid,
    output l2_types_pkg::l2_request_t grant_req,
    output l2_types_pkg::port_id_t    grant_port,
    input  logic                      accept
);
    import l2_types_pkg::*;

    port_id_t last_port;

    // search starts one past the last grant and wraps
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_port = last_port;
        for (int i = 1; i <= `L2_NUM_PORTS; i++) begin
            idx = (int'(last_port) + i) % `L2_NUM_PORTS;
            if (!grant_valid && head_valid[idx]) begin
                grant_valid = 1'b1;
                grant_port = port_id_t'(idx);
            end
        end
    end

    assign grant_req = heads[grant_port];

    // one-hot pop of the granted queue only
    always_comb begin
        for (int p = 0; p < `L2_NUM_PORTS; p++) begin
            pop[p] = accept && grant_valid && (grant_port == port_id_t'(p));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // port 0 wins first
            last_port <= port_id_t'(`L2_NUM_PORTS - 1);
        end else if (accept && grant_valid) begin
            last_port <= grant_port;
        end
    end

endmodule

/* verilog/amo_alu.sv */
// ##############################
// atomic operation unit
// new word from old word and operand
// ##############################

`timescale 1ns/1ns

module amo_alu (
    input  l2_types_pkg::word_t   old_word,
    input  l2_types_pkg::word_t   operand,
    input  l2_types_pkg::amo_op_e op,
    output l2_types_pkg::word_t   new_word
);
    import l2_types_pkg::*;

    logic old_greater;

    // MAX and MIN use signed compare
    assign old_greater = $signed(old_word) > $signed(operand);

    always_comb begin
        case (op)
            AMO_ADD: begin
                new_word = old_word + operand;
            end
            AMO_AND: begin
                new_word = old_word & operand;
            end
            AMO_OR: begin
                new_word = old_word | operand;
            end
            AMO_XOR: begin
                new_word = old_word ^ operand;
            end
            AMO_MAX: begin
                new_word = old_greater ? old_word : operand;
            end
            AMO_MIN: begin
                new_word = old_greater ? operand : old_word;
            end
            default: begin
                // swap
                new_word = operand;
            end
        endcase
    end

endmodule

/* verilog/axi_bridge.sv */
// ##############################
// request to AXI4 bridge
// one request at a time: reads, single
// word writes and read-modify-write atomics
// ##############################

`timescale 1ns/1ns

module axi_bridge (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       grant_valid,
    input  l2_types_pkg::l2_request_t  grant_req,
    input  l2_types_pkg::port_id_t     grant_port,
    output logic                       accept,
    output axi_types_pkg::axi_ar_t     ar,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    input  axi_types_pkg::axi_r_t      r,
    input  logic                       r_valid,
    output axi_types_pkg::axi_aw_t     aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output axi_types_pkg::axi_w_t      w,
    output logic                       w_valid,
    input  logic                       w_ready,
    input  axi_types_pkg::axi_b_t      b,
    input  logic                       b_valid,
    output l2_types_pkg::word_t        amo_old,
    output l2_types_pkg::word_t        amo_operand,
    output l2_types_pkg::amo_op_e      amo_op,
    input  l2_types_pkg::word_t        amo_new,
    output logic                       rsp_valid,
    output l2_types_pkg::l2_response_t rsp
);
    import l2_types_pkg::*;
    import axi_types_pkg::*;

    bridge_state_e state;
    l2_request_t req_r;
    port_id_t port_r;
    word_t amo_new_r;
    logic is_atomic;
    logic r_beat;

    assign is_atomic = (req_r.kind == REQ_ATOMIC);
    // only beats for the latched port count
    assign r_beat = (state == READ_DATA) && r_valid && (r.id == port_r);

    assign accept = (state == IDLE) && grant_valid;

    // valids decode the state, so they hold until the handshake
    assign ar_valid = (state == READ_ADDR);
    assign aw_valid = (state == WRITE_ADDR);
    assign w_valid = (state == WRITE_DATA);

    assign ar.id = port_r;
    assign ar.addr = {req_r.addr, 2'b00};
    assign ar.len = is_atomic ? '0 : axi_len_t'(req_r.len);
    assign ar.size = AXI_SIZE_WORD;
    assign ar.burst = AXI_BURST_INCR;

    assign aw.id = port_r;
    assign aw.addr = {req_r.addr, 2'b00};
    assign aw.len = '0;
    assign aw.size = AXI_SIZE_WORD;
    assign aw.burst = AXI_BURST_INCR;

    // atomics write back the computed word with every byte enabled
    assign w.data = is_atomic ? amo_new_r : req_r.data;
    assign w.strb = is_atomic ? '1 : req_r.be;
    assign w.last = 1'b1;

    assign amo_old = r.data;
    assign amo_operand = req_r.data;
    assign amo_op = req_r.op;

    assign rsp_valid = r_beat;
    assign rsp.port = port_r;
    assign rsp.data = r.data;
    assign rsp.last = is_atomic || r.last;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= grant_req;
            port_r <= grant_port;
        end
        if (r_beat && is_atomic) begin
            amo_new_r <= amo_new;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_valid) begin
                        state <= (grant_req.kind == REQ_WRITE) ? WRITE_ADDR : READ_ADDR;
                    end
                end
                READ_ADDR: begin
                    if (ar_ready) begin
                        state <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (r_beat && is_atomic) begin
                        state <= WRITE_ADDR;
                    end else if (r_beat && r.last) begin
                        state <= IDLE;
                    end
                end
                WRITE_ADDR: begin
                    if (aw_ready) begin
                        state <= WRITE_DATA;
                    end
                end
                WRITE_DATA: begin
                    if (w_ready) begin
                        state <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (b_valid && b.id == port_r) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/l2_axi_top.sv */
// ##############################
// shared memory front end top
// per-port queues, arbiter, AXI bridge
// and atomic unit
// ##############################

`timescale 1ns/1ns

`include "l2_params.svh"

module l2_axi_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`L2_NUM_PORTS-1:0]   req_valid,
    input  l2_types_pkg::l2_request_t  req [`L2_NUM_PORTS],
    output logic [`L2_NUM_PORTS-1:0]   req_full,
    output axi_types_pkg::axi_ar_t     ar,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    input  axi_types_pkg::axi_r_t      r,
    input  logic                       r_valid,
    output axi_types_pkg::axi_aw_t     aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output axi_types_pkg::axi_w_t      w,
    output logic                       w_valid,
    input  logic                       w_ready,
    input  axi_types_pkg::axi_b_t      b,
    input  logic                       b_valid,
    output logic                       rsp_valid,
    output l2_types_pkg::l2_response_t rsp
);
    import l2_types_pkg::*;

    logic [`L2_NUM_PORTS-1:0] head_valid;
    l2_request_t heads [`L2_NUM_PORTS];
    logic [`L2_NUM_PORTS-1:0] pop;
    logic grant_valid;
    l2_request_t grant_req;
    port_id_t grant_port;
    logic accept;
    word_t amo_old;
    word_t amo_operand;
    amo_op_e amo_op;
    word_t amo_new;

    // queues are fed straight from the requester ports
    for (genvar i = 0; i < `L2_NUM_PORTS; i++) begin : g_queue
        port_request_queue port_request_queue_i (
            .clk        (clk),
            .rst        (rst),
            .push       (req_valid[i]),
            .push_req   (req[i]),
            .full       (req_full[i]),
            .head_valid (head_valid[i]),
            .head       (heads[i]),
            .pop        (pop[i])
        );
    end

    request_arbiter request_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .head_valid  (head_valid),
        .heads       (heads),
        .pop         (pop),
        .grant_valid (grant_valid),
        .grant_req   (grant_req),
        .grant_port  (grant_port),
        .accept      (accept)
    );

    axi_bridge axi_bridge_i (
        .clk         (clk),
        .rst         (rst),
        .grant_valid (grant_valid),
        .grant_req   (grant_req),
        .grant_port  (grant_port),
        .accept      (accept),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r           (r),
        .r_valid     (r_valid),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .amo_old     (amo_old),
        .amo_operand (amo_operand),
        .amo_op      (amo_op),
        .amo_new     (amo_new),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    amo_alu amo_alu_i (
        .old_word (amo_old),
        .operand  (amo_operand),
        .op       (amo_op),
        .new_word (amo_new)
    );

endmodule

/* bench/l2_axi_props.sv */
// ##############################
// AXI channel assertions
// bound to the bridge, checks valid
// hold, W last and write ordering
// ##############################

`timescale 1ns/1ns

module l2_axi_props (
    input logic                   clk,
    input logic                   rst,
    input axi_types_pkg::axi_ar_t ar,
    input logic                   ar_valid,
    input logic                   ar_ready,
    input axi_types_pkg::axi_aw_t aw,
    input logic                   aw_valid,
    input logic                   aw_ready,
    input axi_types_pkg::axi_w_t  w,
    input logic                   w_valid,
    input logic                   b_valid
);

    logic write_pending;

    // set by the AW handshake, cleared by the write response
    always_ff @(posedge clk) begin
        if (rst) begin
            write_pending <= 1'b0;
        end else if (aw_valid && aw_ready) begin
            write_pending <= 1'b1;
        end else if (b_valid) begin
            write_pending <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR valid dropped or payload changed before ready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW valid dropped or payload changed before ready");

    w_single_beat: assert property (@(posedge clk) disable iff (rst)
        w_valid |-> w.last)
        else $error("W beat without last");

    no_read_during_write: assert property (@(posedge clk) disable iff (rst)
        write_pending |-> !ar_valid)
        else $error("AR issued while a write waits for B");

    valids_low_after_reset: assert property (@(posedge clk)
        rst |=> !ar_valid && !aw_valid && !w_valid)
        else $error("AXI valid high right after reset");

endmodule

/* bench/l2_axi_checker.sv */
// ##############################
// response checker
// reference memory and expected
// responses per port, queue levels
// ##############################

`timescale 1ns/1ns

`include "l2_params.svh"

module l2_axi_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`L2_NUM_PORTS-1:0]   req_valid,
    input  l2_types_pkg::l2_request_t  req [`L2_NUM_PORTS],
    input  logic [`L2_NUM_PORTS-1:0]   req_full,
    input  logic                       rsp_valid,
    input  l2_types_pkg::l2_response_t rsp,
    input  logic                       b_valid,
    input  axi_types_pkg::axi_b_t      b,
    input  logic                       run_done,
    output int                         error_count,
    output logic                       busy
);
    import l2_types_pkg::*;

    localparam int REGION_WORDS = 64;
    localparam int DEPTH = `L2_QUEUE_DEPTH;

    word_t ref_mem [`L2_NUM_PORTS][REGION_WORDS];
    l2_response_t expected [`L2_NUM_PORTS][$];
    // kinds of accepted requests not yet completed, oldest first
    req_kind_e in_flight [`L2_NUM_PORTS][$];
    int check_count;
    logic full_seen;
    logic reported;

    // odd multiplier spreads every address bit over the word
    function automatic word_t fill_word(int addr);
        return word_t'(addr) * 32'h9e37_79b1 + 32'h3c6e_f372;
    endfunction

    function automatic word_t atomic_result(word_t old_word, word_t operand, amo_op_e op);
        case (op)
            AMO_SWAP: return operand;
            AMO_ADD: return old_word + operand;
            AMO_AND: return old_word & operand;
            AMO_OR: return old_word | operand;
            AMO_XOR: return old_word ^ operand;
            AMO_MAX: return ($signed(old_word) >= $signed(operand)) ? old_word : operand;
            AMO_MIN: return ($signed(old_word) <= $signed(operand)) ? old_word : operand;
            default: return operand;
        endcase
    endfunction

    task automatic note_error(string msg);
        $display("%s", msg);
        error_count++;
    endtask

    // queue plus at most one request inside the bridge
    task automatic check_full_level(int p);
        if (req_full[p]) begin
            full_seen = 1'b1;
            if (in_flight[p].size() < DEPTH) begin
                note_error($sformatf("port %0d shows req_full with only %0d requests waiting",
                    p, in_flight[p].size()));
            end
        end else if (in_flight[p].size() > DEPTH) begin
            note_error($sformatf("port %0d holds %0d requests but req_full is low",
                p, in_flight[p].size()));
        end
    endtask

    task automatic check_response();
        int p;
        l2_response_t exp_rsp;
        p = int'(rsp.port);
        // the oldest open request of the tagged port must be the one returning data
        if (in_flight[p].size() == 0 || in_flight[p][0] == REQ_WRITE) begin
            note_error($sformatf("response tagged port %0d while that port has no read open",
                p));
        end
        if (expected[p].size() == 0) begin
            note_error($sformatf("response for port %0d that no request asked for", p));
        end else begin
            exp_rsp = expected[p].pop_front();
            check_count++;
            if (rsp.data !== exp_rsp.data) begin
                note_error($sformatf("Fail %0t rsp.data port %0d expected %h actual %h",
                    $time, p, exp_rsp.data, rsp.data));
            end
            if (rsp.last !== exp_rsp.last) begin
                note_error($sformatf("Fail %0t rsp.last port %0d expected %b actual %b",
                    $time, p, exp_rsp.last, rsp.last));
            end
            if (rsp.last && in_flight[p].size() > 0 && in_flight[p][0] == REQ_READ) begin
                void'(in_flight[p].pop_front());
            end
        end
    endtask

    task automatic retire_write(int p);
        if (in_flight[p].size() == 0 || in_flight[p][0] == REQ_READ) begin
            note_error($sformatf("write response for port %0d without a pending write", p));
        end else begin
            void'(in_flight[p].pop_front());
        end
    endtask

    task automatic apply_request(int p, l2_request_t rq);
        int off;
        word_t word;
        l2_response_t exp_rsp;
        off = int'(rq.addr[5:0]);
        exp_rsp.port = port_id_t'(p);
        case (rq.kind)
            REQ_READ: begin
                for (int k = 0; k <= int'(rq.len); k++) begin
                    exp_rsp.data = ref_mem[p][(off + k) % REGION_WORDS];
                    exp_rsp.last = (k == int'(rq.len));
                    expected[p].push_back(exp_rsp);
                end
            end
            REQ_WRITE: begin
                word = ref_mem[p][off];
                for (int k = 0; k < `L2_DATA_W / 8; k++) begin
                    if (rq.be[k]) begin
                        word[8*k +: 8] = rq.data[8*k +: 8];
                    end
                end
                ref_mem[p][off] = word;
            end
            default: begin
                exp_rsp.data = ref_mem[p][off];
                exp_rsp.last = 1'b1;
                expected[p].push_back(exp_rsp);
                ref_mem[p][off] = atomic_result(exp_rsp.data, rq.data, rq.op);
            end
        endcase
        in_flight[p].push_back(rq.kind);
    endtask

    task automatic report_totals();
        for (int p = 0; p < `L2_NUM_PORTS; p++) begin
            if (expected[p].size() != 0) begin
                note_error($sformatf("port %0d still waits for %0d responses",
                    p, expected[p].size()));
            end
            if (in_flight[p].size() != 0) begin
                note_error($sformatf("port %0d has %0d requests that never completed",
                    p, in_flight[p].size()));
            end
        end
        if (!full_seen) begin
            note_error("req_full never rose on any port");
        end
        $display("checker: %0d responses checked, %0d errors", check_count, error_count);
        reported = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            error_count = 0;
            check_count = 0;
            full_seen = 1'b0;
            reported = 1'b0;
            busy = 1'b0;
            for (int p = 0; p < `L2_NUM_PORTS; p++) begin
                expected[p].delete();
                in_flight[p].delete();
                for (int k = 0; k < REGION_WORDS; k++) begin
                    ref_mem[p][k] = fill_word(p * REGION_WORDS + k);
                end
            end
        end else begin
            // levels first, they reflect the state before this edge
            for (int p = 0; p < `L2_NUM_PORTS; p++) begin
                check_full_level(p);
            end
            if (rsp_valid) begin
                check_response();
            end
            if (b_valid) begin
                retire_write(int'(b.id));
            end
            for (int p = 0; p < `L2_NUM_PORTS; p++) begin
                if (req_valid[p] && !req_full[p]) begin
                    apply_request(p, req[p]);
                end
            end
            busy = 1'b0;
            for (int p = 0; p < `L2_NUM_PORTS; p++) begin
                if (in_flight[p].size() != 0 || expected[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
            if (run_done && !reported) begin
                report_totals();
            end
        end
    end

endmodule

/* bench/l2_axi_tb.sv */
// ##############################
// l2 front end testbench
// random requests per port, AXI
// memory model and watchdog
// ##############################

`timescale 1ns/1ns

`include "l2_params.svh"

module l2_axi_tb;
    import l2_types_pkg::*;
    import axi_types_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_REQUESTS = 400;
    localparam int REGION_WORDS = 64;
    localparam int MEM_WORDS = REGION_WORDS * `L2_NUM_PORTS;

    logic clk;
    logic rst = 1'b1;
    logic [`L2_NUM_PORTS-1:0] req_valid = '0;
    l2_request_t req [`L2_NUM_PORTS] = '{default: '0};
    logic [`L2_NUM_PORTS-1:0] req_full;
    axi_ar_t ar;
    logic ar_valid;
    logic ar_ready = 1'b0;
    axi_r_t r = '0;
    logic r_valid = 1'b0;
    axi_aw_t aw;
    logic aw_valid;
    logic aw_ready = 1'b0;
    axi_w_t w;
    logic w_valid;
    logic w_ready = 1'b0;
    axi_b_t b = '0;
    logic b_valid = 1'b0;
    logic rsp_valid;
    l2_response_t rsp;

    logic run_done = 1'b0;
    int error_count;
    logic busy;
    int offered = 0;

    // memory model state
    word_t mem [MEM_WORDS];
    logic [7:0] rd_addr = '0;
    int rd_left = 0;
    port_id_t rd_id = '0;
    logic [7:0] wr_addr = '0;
    port_id_t wr_id = '0;
    logic b_pend = 1'b0;

    function automatic word_t fill_word(int addr);
        return word_t'(addr) * 32'h9e37_79b1 + 32'h3c6e_f372;
    endfunction

    // stays inside the port's own 64 word region, bursts included
    function automatic l2_request_t random_request(int port);
        l2_request_t rq;
        rq.kind = req_kind_e'($urandom_range(2, 0));
        rq.addr = word_addr_t'(port * REGION_WORDS + $urandom_range(REGION_WORDS - 4, 0));
        rq.len = burst_len_t'($urandom_range(3, 0));
        rq.be = byte_en_t'($urandom_range(15, 0));
        rq.op = amo_op_e'($urandom_range(6, 0));
        rq.data = $urandom;
        return rq;
    endfunction

    l2_axi_top l2_axi_top_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_full  (req_full),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    l2_axi_checker l2_axi_checker_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .req_full    (req_full),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .b_valid     (b_valid),
        .b           (b),
        .run_done    (run_done),
        .error_count (error_count),
        .busy        (busy)
    );

    bind axi_bridge l2_axi_props l2_axi_props_i (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .b_valid  (b_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fill_word(a);
        end
    end

    // requesters, a request waits while its queue is full
    always @(posedge clk) begin
        if (rst) begin
            req_valid <= '0;
        end else begin
            for (int i = 0; i < `L2_NUM_PORTS; i++) begin
                if (!(req_valid[i] && req_full[i])) begin
                    if (offered < NUM_REQUESTS && $urandom_range(3, 0) != 0) begin
                        req_valid[i] <= 1'b1;
                        req[i] <= random_request(i);
                        offered++;
                    end else begin
                        req_valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // AXI memory model with random stalls on every channel
    always @(posedge clk) begin
        word_t merged;
        if (rst) begin
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            rd_left <= 0;
            b_pend <= 1'b0;
        end else begin
            ar_ready <= ($urandom_range(3, 0) != 0);
            aw_ready <= ($urandom_range(3, 0) != 0);
            w_ready <= ($urandom_range(3, 0) != 0);
            if (ar_valid && ar_ready) begin
                rd_addr <= ar.addr[9:2];
                rd_left <= int'(ar.len) + 1;
                rd_id <= ar.id;
            end
            r_valid <= 1'b0;
            if (rd_left != 0 && $urandom_range(2, 0) != 0) begin
                r_valid <= 1'b1;
                r.id <= rd_id;
                r.data <= mem[rd_addr];
                r.resp <= '0;
                r.last <= (rd_left == 1);
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1;
            end
            if (aw_valid && aw_ready) begin
                wr_addr <= aw.addr[9:2];
                wr_id <= aw.id;
            end
            if (w_valid && w_ready) begin
                merged = mem[wr_addr];
                for (int k = 0; k < `L2_DATA_W / 8; k++) begin
                    if (w.strb[k]) begin
                        merged[8*k +: 8] = w.data[8*k +: 8];
                    end
                end
                mem[wr_addr] <= merged;
                b_pend <= 1'b1;
            end
            b_valid <= 1'b0;
            if (b_pend && $urandom_range(2, 0) != 0) begin
                b_valid <= 1'b1;
                b.id <= wr_id;
                b.resp <= '0;
                b_pend <= 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(10523));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait (offered == NUM_REQUESTS);
        do begin
            @(negedge clk);
        end while (req_valid != '0 || busy);
        repeat (4) @(negedge clk);
        run_done = 1'b1;
        @(negedge clk);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog, 40 cycles per request
    initial begin
        #(NUM_REQUESTS * 40 * CLK_PERIOD);
        $display("watchdog: run still busy after %0d cycles, stopping", NUM_REQUESTS * 40);
        run_done = 1'b1;
        @(negedge clk);
        @(negedge clk);
        $display("Something failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+verilog
verilog/l2_types_pkg.sv
verilog/axi_types_pkg.sv
verilog/port_request_queue.sv
verilog/request_arbiter.sv
verilog/amo_alu.sv
verilog/axi_bridge.sv
verilog/l2_axi_top.sv
bench/l2_axi_props.sv
bench/l2_axi_checker.sv
bench/l2_axi_tb.sv

/* Makefile */
# Verilator flow for the l2 AXI front end testbench

SIM := obj_dir/l2_axi_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module l2_axi_tb -o l2_axi_sim

run: compile
	$(SIM) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
